// ==== list.f ====
exec_pkg.sv
exec_operand_if.sv
alu.sv
branch_unit.sv
lsu_request.sv
writeback_reg.sv
exec_top.sv
exec_checker.sv
tb_exec.sv

// ==== Bender.yml ====
package:
  name: exec_stage

sources:
  - exec_pkg.sv
  - exec_operand_if.sv
  - alu.sv
  - branch_unit.sv
  - lsu_request.sv
  - writeback_reg.sv
  - exec_top.sv
  - target: test
    files:
      - exec_checker.sv
      - tb_exec.sv

// ==== tb_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exec;

    localparam int reset_cycles  = 16;
    localparam int random_cycles = 1500;
    localparam int wait_limit    = 100;
    localparam int op_count      = int'(exec_pkg::SW) + 1;

    logic               clk = 1'b0;
    logic               reset;
    logic               check_en;
    int                 seed;
    logic               timed_out;
    int                 checks;
    int                 errors;
    int                 test_count;
    int                 checks_before;
    int                 errors_before;

    // DUT inputs
    logic               in_valid;
    logic               out_ready;
    exec_pkg::op_e      op;
    exec_pkg::word_t    pc;
    exec_pkg::word_t    rs1_val;
    exec_pkg::word_t    rs2_val;
    exec_pkg::word_t    imm_val;
    exec_pkg::tag_t     tag;

    // DUT outputs
    logic               in_ready, out_valid, write_enable, killed;
    logic               jump, mem_read_enable;
    exec_pkg::op_e      op_out;
    exec_pkg::word_t    result, jump_target, mem_address, mem_write_data;
    exec_pkg::strb_t    mem_write_enable;

    // Reference model state
    logic               model_valid;
    exec_pkg::op_e      model_op;
    exec_pkg::word_t    model_result;
    logic               model_write_enable;
    exec_pkg::tag_t     model_tag;

    // Predictions for the instruction currently driven
    logic               exp_in_ready, exp_killed, exp_jump, exp_mem_read_enable;
    logic               pred_intent;
    exec_pkg::word_t    pred_result, exp_jump_target, exp_mem_address, exp_mem_write_data;
    exec_pkg::strb_t    exp_mem_write_enable;

    always #4 clk = ~clk;

    exec_top UUT (
        .clk                (clk),
        .reset              (reset),
        .in_valid_i         (in_valid),
        .in_ready_o         (in_ready),
        .op_i               (op),
        .pc_i               (pc),
        .rs1_val_i          (rs1_val),
        .rs2_val_i          (rs2_val),
        .imm_val_i          (imm_val),
        .tag_i              (tag),
        .out_valid_o        (out_valid),
        .out_ready_i        (out_ready),
        .write_enable_o     (write_enable),
        .op_o               (op_out),
        .result_o           (result),
        .jump_o             (jump),
        .jump_target_o      (jump_target),
        .mem_address_o      (mem_address),
        .mem_read_enable_o  (mem_read_enable),
        .mem_write_enable_o (mem_write_enable),
        .mem_write_data_o   (mem_write_data),
        .killed_o           (killed)
    );

    exec_checker u_checker (
        .clk                    (clk),
        .enable_i               (check_en),
        .in_valid_i             (in_valid),
        .in_ready_i             (in_ready),
        .out_valid_i            (out_valid),
        .op_i                   (op_out),
        .result_i               (result),
        .write_enable_i         (write_enable),
        .jump_i                 (jump),
        .jump_target_i          (jump_target),
        .mem_address_i          (mem_address),
        .mem_read_enable_i      (mem_read_enable),
        .mem_write_enable_i     (mem_write_enable),
        .mem_write_data_i       (mem_write_data),
        .killed_i               (killed),
        .exp_in_ready_i         (exp_in_ready),
        .exp_out_valid_i        (model_valid),
        .exp_op_i               (model_op),
        .exp_result_i           (model_result),
        .exp_write_enable_i     (model_write_enable),
        .exp_jump_i             (exp_jump),
        .exp_jump_target_i      (exp_jump_target),
        .exp_mem_address_i      (exp_mem_address),
        .exp_mem_read_enable_i  (exp_mem_read_enable),
        .exp_mem_write_enable_i (exp_mem_write_enable),
        .exp_mem_write_data_i   (exp_mem_write_data),
        .exp_killed_i           (exp_killed),
        .checks_o               (checks),
        .errors_o               (errors)
    );

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic chance(input int pct);
        return ({$random(seed)} % 100) < pct;
    endfunction

    task automatic predict;
        exec_pkg::word_t                sum;
        logic [exec_pkg::shamt_w-1:0]   shamt;
        logic                           cond;
        logic                           live;
        sum          = rs1_val + rs2_val;
        shamt        = rs2_val[exec_pkg::shamt_w-1:0];
        exp_in_ready = !model_valid || out_ready;
        exp_killed   = (tag != model_tag);
        live         = in_valid && exp_in_ready && !exp_killed;

        case (op)
            exec_pkg::SUB:  pred_result = rs1_val - rs2_val;
            exec_pkg::SLT:  pred_result = ($signed(rs1_val) < $signed(rs2_val)) ? 32'd1 : 32'd0;
            exec_pkg::SLTU: pred_result = (rs1_val < rs2_val) ? 32'd1 : 32'd0;
            exec_pkg::XOR:  pred_result = rs1_val ^ rs2_val;
            exec_pkg::OR:   pred_result = rs1_val | rs2_val;
            exec_pkg::AND:  pred_result = rs1_val & rs2_val;
            exec_pkg::SLL:  pred_result = rs1_val << shamt;
            exec_pkg::SRL:  pred_result = rs1_val >> shamt;
            exec_pkg::SRA:  pred_result = $signed(rs1_val) >>> shamt;
            exec_pkg::LUI:  pred_result = rs2_val;
            exec_pkg::JAL,
            exec_pkg::JALR: pred_result = pc + exec_pkg::pc_step;
            default:        pred_result = sum;
        endcase
        pred_intent = !(op inside {exec_pkg::NOP, exec_pkg::SB, exec_pkg::SH, exec_pkg::SW,
                                   exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::BLT,
                                   exec_pkg::BLTU, exec_pkg::BGE, exec_pkg::BGEU});

        case (op)
            exec_pkg::BEQ:  cond = (rs1_val == rs2_val);
            exec_pkg::BNE:  cond = (rs1_val != rs2_val);
            exec_pkg::BLT:  cond = ($signed(rs1_val) < $signed(rs2_val));
            exec_pkg::BLTU: cond = (rs1_val < rs2_val);
            exec_pkg::BGE:  cond = ($signed(rs1_val) >= $signed(rs2_val));
            exec_pkg::BGEU: cond = (rs1_val >= rs2_val);
            exec_pkg::JAL,
            exec_pkg::JALR: cond = 1'b1;
            default:        cond = 1'b0;
        endcase
        exp_jump = live && cond;
        case (op)
            exec_pkg::JALR: exp_jump_target = sum & 32'hffff_fffe;
            exec_pkg::JAL:  exp_jump_target = sum;
            default:        exp_jump_target = pc + imm_val;
        endcase

        // Memory request
        exp_mem_address     = sum & 32'hffff_fffc;
        exp_mem_read_enable = live && (op inside {exec_pkg::LB, exec_pkg::LBU, exec_pkg::LH,
                                                  exec_pkg::LHU, exec_pkg::LW});
        case (op)
            exec_pkg::SB: exp_mem_write_enable = 4'b0001 << sum[1:0];
            exec_pkg::SH: exp_mem_write_enable = sum[1] ? 4'b1100 : 4'b0011;
            exec_pkg::SW: exp_mem_write_enable = 4'b1111;
            default:      exp_mem_write_enable = 4'b0000;
        endcase
        if (!live) begin
            exp_mem_write_enable = 4'b0000;
        end
        case (op)
            exec_pkg::SB: exp_mem_write_data = {4{imm_val[7:0]}};
            exec_pkg::SH: exp_mem_write_data = {2{imm_val[15:0]}};
            default:      exp_mem_write_data = imm_val;
        endcase
    endtask

    // Applies what the last rising edge did to the model
    task automatic commit_cycle;
        if (in_valid && exp_in_ready) begin
            model_valid        = 1'b1;
            model_op           = op;
            model_result       = pred_result;
            model_write_enable = pred_intent && !exp_killed;
            if (exp_jump) begin
                model_tag = model_tag + 1'b1;
            end
        end else if (out_ready) begin
            model_valid = 1'b0;
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic next_cycle;
        @(negedge clk);
        commit_cycle();
    endtask

    // tag_back 0 gives the live tag, 1 the tag before the last jump
    task automatic issue(input exec_pkg::op_e new_op, input exec_pkg::word_t a,
                         input exec_pkg::word_t b, input exec_pkg::word_t c,
                         input int tag_back, input logic ready);
        next_cycle();
        in_valid  = 1'b1;
        out_ready = ready;
        op        = new_op;
        pc        = $random(seed) & 32'hffff_fffc;
        rs1_val   = a;
        rs2_val   = b;
        imm_val   = c;
        tag       = exec_pkg::tag_t'(model_tag - tag_back);
        predict();
    endtask

    task automatic idle(input logic ready);
        next_cycle();
        in_valid  = 1'b0;
        out_ready = ready;
        predict();
    endtask

    task automatic random_inputs;
        int pick;
        in_valid = chance(70);
        op       = exec_pkg::op_e'({$random(seed)} % op_count);
        pc       = $random(seed) & 32'hffff_fffc;
        rs1_val  = $random(seed);
        rs2_val  = chance(25) ? rs1_val : $random(seed);
        imm_val  = $random(seed);
        pick     = {$random(seed)} % 10;
        if (pick < 7) begin
            tag = model_tag;
        end else if (pick < 9) begin
            tag = model_tag - 1'b1;
        end else begin
            tag = exec_pkg::tag_t'($random(seed));
        end
    endtask

    task automatic wait_in_ready_low;
        int count;
        count = 0;
        next_cycle();
        predict();
        while (in_ready && count < wait_limit) begin
            next_cycle();
            predict();
            count++;
        end
        if (in_ready) begin
            timed_out = 1'b1;
            $display("Timeout: in_ready_o stayed high with the output register full");
        end
    endtask

    task automatic wait_out_valid_low;
        int count;
        count = 0;
        next_cycle();
        predict();
        while (out_valid && count < wait_limit) begin
            next_cycle();
            predict();
            count++;
        end
        if (out_valid) begin
            timed_out = 1'b1;
            $display("Timeout: out_valid_o did not fall with out_ready_i high");
        end
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        #1;
        $display("test %-14s %0d checks, %0d errors", name,
                 checks - checks_before, errors - errors_before);
        checks_before = checks;
        errors_before = errors;
        test_count++;
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        reset              = 1'b1;
        check_en           = 1'b0;
        seed               = 32'h111a;
        timed_out          = 1'b0;
        test_count         = 0;
        checks_before      = 0;
        errors_before      = 0;
        in_valid           = 1'b0;
        out_ready          = 1'b0;
        op                 = exec_pkg::NOP;
        pc                 = '0;
        rs1_val            = '0;
        rs2_val            = '0;
        imm_val            = '0;
        tag                = '0;
        model_valid        = 1'b0;
        model_op           = exec_pkg::NOP;
        model_result       = '0;
        model_write_enable = 1'b0;
        model_tag          = '0;
        predict();

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset    = 1'b0;
        predict();
        check_en = 1'b1;

        // Quiet outputs after reset and a live tag 0
        idle(1'b0);
        idle(1'b1);
        issue(exec_pkg::ADD, $random(seed), $random(seed), $random(seed), 0, 1'b1);
        idle(1'b1);
        finish_test("reset");

        // Every op once with the live tag
        for (int i = 0; i < op_count; i++) begin
            issue(exec_pkg::op_e'(i), $random(seed), $random(seed), $random(seed), 0, 1'b1);
        end
        idle(1'b1);
        finish_test("all_ops");

        // Old tag after a taken jump is dropped everywhere
        issue(exec_pkg::JAL, $random(seed), $random(seed), $random(seed), 0, 1'b1);
        issue(exec_pkg::ADD, $random(seed), $random(seed), $random(seed), 1, 1'b1);
        issue(exec_pkg::LW, $random(seed), $random(seed), $random(seed), 1, 1'b1);
        issue(exec_pkg::SW, $random(seed), $random(seed), $random(seed), 1, 1'b1);
        issue(exec_pkg::BEQ, 32'h55, 32'h55, $random(seed), 1, 1'b1);
        issue(exec_pkg::ADD, $random(seed), $random(seed), $random(seed), 0, 1'b1);
        issue(exec_pkg::BEQ, 32'h77, 32'h77, $random(seed), 0, 1'b1);
        issue(exec_pkg::SB, $random(seed), $random(seed), $random(seed), 1, 1'b1);
        issue(exec_pkg::JALR, $random(seed), $random(seed), $random(seed), 0, 1'b1);
        idle(1'b1);
        finish_test("kill");

        // Stall the output, then release it
        issue(exec_pkg::ADD, $random(seed), $random(seed), $random(seed), 0, 1'b0);
        issue(exec_pkg::XOR, $random(seed), $random(seed), $random(seed), 0, 1'b0);
        wait_in_ready_low();
        repeat (4) begin
            next_cycle();
            predict();
        end
        next_cycle();
        out_ready = 1'b1;
        predict();
        idle(1'b1);
        wait_out_valid_low();
        finish_test("back_pressure");

        // Random traffic with random downstream ready
        for (int i = 0; i < random_cycles; i++) begin
            next_cycle();
            // Upstream keeps a stalled instruction unchanged
            if (!(in_valid && !exp_in_ready)) begin
                random_inputs();
            end
            out_ready = chance(60);
            predict();
        end
        idle(1'b1);
        wait_out_valid_low();
        finish_test("random");

        $display("%0d tests, %0d checks, %0d errors", test_count, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== exec_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_checker (
    input  logic                clk,
    input  logic                enable_i,
    input  logic                in_valid_i,

    // Observed DUT outputs
    input  logic                in_ready_i,
    input  logic                out_valid_i,
    input  exec_pkg::op_e       op_i,
    input  exec_pkg::word_t     result_i,
    input  logic                write_enable_i,
    input  logic                jump_i,
    input  exec_pkg::word_t     jump_target_i,
    input  exec_pkg::word_t     mem_address_i,
    input  logic                mem_read_enable_i,
    input  exec_pkg::strb_t     mem_write_enable_i,
    input  exec_pkg::word_t     mem_write_data_i,
    input  logic                killed_i,

    // Values predicted by the reference model
    input  logic                exp_in_ready_i,
    input  logic                exp_out_valid_i,
    input  exec_pkg::op_e       exp_op_i,
    input  exec_pkg::word_t     exp_result_i,
    input  logic                exp_write_enable_i,
    input  logic                exp_jump_i,
    input  exec_pkg::word_t     exp_jump_target_i,
    input  exec_pkg::word_t     exp_mem_address_i,
    input  logic                exp_mem_read_enable_i,
    input  exec_pkg::strb_t     exp_mem_write_enable_i,
    input  exec_pkg::word_t     exp_mem_write_data_i,
    input  logic                exp_killed_i,

    output int                  checks_o,
    output int                  errors_o
);

    int check_count = 0;
    int error_count = 0;

    assign checks_o = check_count;
    assign errors_o = error_count;

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        check_count = check_count + 1;
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("Error: %s is 0x%08h, expected 0x%08h (time %0t)",
                     name, actual, expected, $time);
        end
    endtask

    // Inputs change on the falling edge, so everything is settled here
    always @(posedge clk) begin
        if (enable_i) begin
            compare("in_ready_o", in_ready_i, exp_in_ready_i);
            compare("out_valid_o", out_valid_i, exp_out_valid_i);
            if (exp_out_valid_i) begin
                compare("op_o", op_i, exp_op_i);
                compare("result_o", result_i, exp_result_i);
                compare("write_enable_o", write_enable_i, exp_write_enable_i);
            end
            compare("killed_o", killed_i, exp_killed_i);
            compare("jump_o", jump_i, exp_jump_i);
            compare("mem_read_enable_o", mem_read_enable_i, exp_mem_read_enable_i);
            compare("mem_write_enable_o", mem_write_enable_i, exp_mem_write_enable_i);
            if (exp_jump_i) begin
                compare("jump_target_o", jump_target_i, exp_jump_target_i);
            end
            if (in_valid_i) begin
                compare("mem_address_o", mem_address_i, exp_mem_address_i);
            end
            // Store data only matters when a lane is written
            if (exp_mem_write_enable_i != '0) begin
                compare("mem_write_data_o", mem_write_data_i, exp_mem_write_data_i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_top (
    input  logic                clk,
    input  logic                reset,

    // Decoded instruction in
    input  logic                in_valid_i,
    output logic                in_ready_o,
    input  exec_pkg::op_e       op_i,
    input  exec_pkg::word_t     pc_i,
    input  exec_pkg::word_t     rs1_val_i,
    input  exec_pkg::word_t     rs2_val_i,
    input  exec_pkg::word_t     imm_val_i,
    input  exec_pkg::tag_t      tag_i,

    // Registered result out
    output logic                out_valid_o,
    input  logic                out_ready_i,
    output logic                write_enable_o,
    output exec_pkg::op_e       op_o,
    output exec_pkg::word_t     result_o,

    // Combinational in the fire cycle
    output logic                jump_o,
    output exec_pkg::word_t     jump_target_o,
    output exec_pkg::word_t     mem_address_o,
    output logic                mem_read_enable_o,
    output exec_pkg::strb_t     mem_write_enable_o,
    output exec_pkg::word_t     mem_write_data_o,
    output logic                killed_o
);

    exec_operand_if     operand_bus ();

    logic               fire;
    exec_pkg::word_t    sum_result;
    exec_pkg::word_t    second_sum;
    exec_pkg::word_t    alu_result;
    logic               write_intent;

    assign operand_bus.op      = op_i;
    assign operand_bus.pc      = pc_i;
    assign operand_bus.rs1_val = rs1_val_i;
    assign operand_bus.rs2_val = rs2_val_i;
    assign operand_bus.imm_val = imm_val_i;

    assign fire = in_valid_i && in_ready_o;

    //////////////////////////////////////////////////
    // Units
    //////////////////////////////////////////////////

    alu u_alu (
        .operand_i      (operand_bus.sink),
        .sum_result_o   (sum_result),
        .second_sum_o   (second_sum),
        .result_o       (alu_result),
        .write_intent_o (write_intent)
    );

    branch_unit u_branch_unit (
        .clk            (clk),
        .reset          (reset),
        .fire_i         (fire),
        .operand_i      (operand_bus.sink),
        .tag_i          (tag_i),
        .sum_result_i   (sum_result),
        .second_sum_i   (second_sum),
        .killed_o       (killed_o),
        .jump_o         (jump_o),
        .jump_target_o  (jump_target_o)
    );

    lsu_request u_lsu_request (
        .fire_i             (fire),
        .killed_i           (killed_o),
        .operand_i          (operand_bus.sink),
        .sum_result_i       (sum_result),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

    writeback_reg u_writeback_reg (
        .clk            (clk),
        .reset          (reset),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .killed_i       (killed_o),
        .op_i           (op_i),
        .result_i       (alu_result),
        .write_intent_i (write_intent),
        .out_valid_o    (out_valid_o),
        .out_ready_i    (out_ready_i),
        .op_o           (op_o),
        .result_o       (result_o),
        .write_enable_o (write_enable_o)
    );

endmodule

`default_nettype wire

// ==== writeback_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_reg (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid_i,
    output logic                in_ready_o,
    input  logic                killed_i,
    input  exec_pkg::op_e       op_i,
    input  exec_pkg::word_t     result_i,
    input  logic                write_intent_i,
    output logic                out_valid_o,
    input  logic                out_ready_i,
    output exec_pkg::op_e       op_o,
    output exec_pkg::word_t     result_o,
    output logic                write_enable_o
);

    logic load;

    // Accept when empty or when the current entry leaves this cycle
    assign in_ready_o = !out_valid_o || out_ready_i;
    assign load       = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_o    <= 1'b0;
            write_enable_o <= 1'b0;
        end else if (load) begin
            out_valid_o    <= 1'b1;
            write_enable_o <= write_intent_i && !killed_i;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (load) begin
            op_o     <= op_i;
            result_o <= result_i;
        end
    end

endmodule

`default_nettype wire

// ==== lsu_request.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_request (
    input  logic                fire_i,
    input  logic                killed_i,
    exec_operand_if.sink        operand_i,
    input  exec_pkg::word_t     sum_result_i,
    output exec_pkg::word_t     mem_address_o,
    output logic                mem_read_enable_o,
    output exec_pkg::strb_t     mem_write_enable_o,
    output exec_pkg::word_t     mem_write_data_o
);

    logic               enable;
    logic               is_load;
    exec_pkg::strb_t    strobe;

    // Only a live, accepted instruction may touch memory
    assign enable = fire_i && !killed_i;

    // Word aligned address with byte lanes chosen by strobes
    assign mem_address_o = {sum_result_i[exec_pkg::xlen-1:2], 2'b00};

    assign is_load = operand_i.op inside {exec_pkg::LB, exec_pkg::LBU, exec_pkg::LH,
                                          exec_pkg::LHU, exec_pkg::LW};

    assign mem_read_enable_o = enable && is_load;

    //////////////////////////////////////////////////
    // Store strobes and data
    //////////////////////////////////////////////////

    always_comb begin
        unique case (operand_i.op)
            exec_pkg::SB: strobe = exec_pkg::strb_t'(1) << sum_result_i[1:0];
            exec_pkg::SH: strobe = sum_result_i[1] ? 4'b1100 : 4'b0011;
            exec_pkg::SW: strobe = 4'b1111;
            default:      strobe = 4'b0000;
        endcase
    end

    assign mem_write_enable_o = enable ? strobe : '0;

    // Replicate so every lane carries the value
    always_comb begin
        unique case (operand_i.op)
            exec_pkg::SB: mem_write_data_o = {4{operand_i.imm_val[7:0]}};
            exec_pkg::SH: mem_write_data_o = {2{operand_i.imm_val[15:0]}};
            default:      mem_write_data_o = operand_i.imm_val;
        endcase
    end

endmodule

`default_nettype wire

// ==== branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                fire_i,
    exec_operand_if.sink        operand_i,
    input  exec_pkg::tag_t      tag_i,
    input  exec_pkg::word_t     sum_result_i,
    input  exec_pkg::word_t     second_sum_i,
    output logic                killed_o,
    output logic                jump_o,
    output exec_pkg::word_t     jump_target_o
);

    exec_pkg::tag_t     curr_tag;
    logic               equal;
    logic               less_than;
    logic               less_than_unsigned;
    logic               taken;

    //////////////////////////////////////////////////
    // Kill on tag mismatch
    //////////////////////////////////////////////////

    assign killed_o = (tag_i != curr_tag);

    //////////////////////////////////////////////////
    // Branch condition
    //////////////////////////////////////////////////

    assign equal              = operand_i.rs1_val == operand_i.rs2_val;
    assign less_than          = $signed(operand_i.rs1_val) < $signed(operand_i.rs2_val);
    assign less_than_unsigned = operand_i.rs1_val < operand_i.rs2_val;

    always_comb begin
        unique case (operand_i.op)
            exec_pkg::BEQ:  taken = equal;
            exec_pkg::BNE:  taken = !equal;
            exec_pkg::BLT:  taken = less_than;
            exec_pkg::BLTU: taken = less_than_unsigned;
            exec_pkg::BGE:  taken = !less_than;
            exec_pkg::BGEU: taken = !less_than_unsigned;
            exec_pkg::JAL,
            exec_pkg::JALR: taken = 1'b1;
            default:        taken = 1'b0;
        endcase
    end

    assign jump_o = fire_i && taken && !killed_o;

    // jalr target must be halfword aligned
    always_comb begin
        unique case (operand_i.op)
            exec_pkg::JALR: jump_target_o = {sum_result_i[exec_pkg::xlen-1:1], 1'b0};
            exec_pkg::JAL:  jump_target_o = sum_result_i;
            default:        jump_target_o = second_sum_i;
        endcase
    end

    //////////////////////////////////////////////////
    // Tag register
    //////////////////////////////////////////////////

    // Next tag marks the new instruction stream
    always_ff @(posedge clk) begin
        if (reset) begin
            curr_tag <= '0;
        end else if (jump_o) begin
            curr_tag <= curr_tag + exec_pkg::tag_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    exec_operand_if.sink            operand_i,
    output exec_pkg::word_t         sum_result_o,
    output exec_pkg::word_t         second_sum_o,
    output exec_pkg::word_t         result_o,
    output logic                    write_intent_o
);

    exec_pkg::word_t                sum2_op_a;
    exec_pkg::word_t                sum2_op_b;
    logic [exec_pkg::shamt_w-1:0]   shamt;
    logic                           less_than;
    logic                           less_than_unsigned;

    //////////////////////////////////////////////////
    // Adders
    //////////////////////////////////////////////////

    assign sum_result_o = operand_i.rs1_val + operand_i.rs2_val;

    // Second adder serves sub, return address and branch target
    always_comb begin
        unique case (operand_i.op)
            exec_pkg::SUB: begin
                sum2_op_a = operand_i.rs1_val;
                sum2_op_b = -operand_i.rs2_val;
            end
            exec_pkg::JAL, exec_pkg::JALR: begin
                sum2_op_a = operand_i.pc;
                sum2_op_b = exec_pkg::word_t'(exec_pkg::pc_step);
            end
            default: begin
                sum2_op_a = operand_i.pc;
                sum2_op_b = operand_i.imm_val;
            end
        endcase
    end

    assign second_sum_o = sum2_op_a + sum2_op_b;

    //////////////////////////////////////////////////
    // Compare and result select
    //////////////////////////////////////////////////

    assign shamt              = operand_i.rs2_val[exec_pkg::shamt_w-1:0];
    assign less_than          = $signed(operand_i.rs1_val) < $signed(operand_i.rs2_val);
    assign less_than_unsigned = operand_i.rs1_val < operand_i.rs2_val;

    always_comb begin
        unique case (operand_i.op)
            exec_pkg::JAL,
            exec_pkg::JALR,
            exec_pkg::SUB:  result_o = second_sum_o;
            exec_pkg::SLT:  result_o = {{(exec_pkg::xlen-1){1'b0}}, less_than};
            exec_pkg::SLTU: result_o = {{(exec_pkg::xlen-1){1'b0}}, less_than_unsigned};
            exec_pkg::XOR:  result_o = operand_i.rs1_val ^ operand_i.rs2_val;
            exec_pkg::OR:   result_o = operand_i.rs1_val | operand_i.rs2_val;
            exec_pkg::AND:  result_o = operand_i.rs1_val & operand_i.rs2_val;
            exec_pkg::SLL:  result_o = operand_i.rs1_val << shamt;
            exec_pkg::SRL:  result_o = operand_i.rs1_val >> shamt;
            exec_pkg::SRA:  result_o = $signed(operand_i.rs1_val) >>> shamt;
            exec_pkg::LUI:  result_o = operand_i.rs2_val;
            // Loads end up here with their address
            default:        result_o = sum_result_o;
        endcase
    end

    // No register write for stores, branches and bubbles
    always_comb begin
        unique case (operand_i.op)
            exec_pkg::NOP,
            exec_pkg::SB, exec_pkg::SH, exec_pkg::SW,
            exec_pkg::BEQ, exec_pkg::BNE,
            exec_pkg::BLT, exec_pkg::BLTU,
            exec_pkg::BGE, exec_pkg::BGEU: write_intent_o = 1'b0;
            default:                       write_intent_o = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== exec_operand_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface exec_operand_if;

    exec_pkg::op_e   op;
    exec_pkg::word_t pc;
    exec_pkg::word_t rs1_val;
    exec_pkg::word_t rs2_val;
    // Immediate, or store data for stores
    exec_pkg::word_t imm_val;

    modport source (
        output op, pc, rs1_val, rs2_val, imm_val
    );

    modport sink (
        input op, pc, rs1_val, rs2_val, imm_val
    );

endinterface

`default_nettype wire

// ==== exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    // Data and address width
    localparam int xlen = 32;

    // Instruction tag that wraps around
    localparam int tag_w = 3;

    // Shift amount taken from operand two
    localparam int shamt_w = 5;

    // One strobe per byte of a word
    localparam int strb_w = xlen / 8;

    // Return address offset for jal and jalr
    localparam int pc_step = 4;

    typedef logic [xlen-1:0]   word_t;
    typedef logic [tag_w-1:0]  tag_t;
    typedef logic [strb_w-1:0] strb_t;

    //////////////////////////////////////////////////
    // Operations
    //////////////////////////////////////////////////

    typedef enum logic [4:0] {
        NOP,
        // Arithmetic and compare
        ADD,
        SUB,
        SLT,
        SLTU,
        // Bitwise
        XOR,
        OR,
        AND,
        // Shifts
        SLL,
        SRL,
        SRA,
        // Upper immediate with operand two already shifted
        LUI,
        // Unconditional jumps
        JAL,
        JALR,
        // Conditional branches
        BEQ,
        BNE,
        BLT,
        BLTU,
        BGE,
        BGEU,
        // Loads
        LB,
        LBU,
        LH,
        LHU,
        LW,
        // Stores
        SB,
        SH,
        SW
    } op_e;

endpackage

`default_nettype wire
